// ==== design/aud_settings.svh ====
`ifndef AUD_SETTINGS_SVH
`define AUD_SETTINGS_SVH

// SRAM and sample widths
`define AUD_ADDR_W      20
`define AUD_SAMPLE_W    16
`define AUD_SPEED_W     4

// system clocks per half bclk period, frame is 32 bclks
`define AUD_BCLK_DIV    2

// host register port
`define AUD_WB_ADR_W    2
`define AUD_REG_CTRL    2'd0
`define AUD_REG_END     2'd1
`define AUD_REG_STATUS  2'd2

`endif

// ==== design/aud_pkg.sv ====
`default_nettype none

package aud_pkg;

    // playback engine state, also read back through STATUS[1:0]
    typedef enum logic [1:0] {
        S_IDLE      = 2'd0,
        S_PAUSE     = 2'd1,
        S_PLAY      = 2'd2,
        S_BACKTRACK = 2'd3
    } play_state_t;

    // slow play output mode, CTRL[4]
    typedef enum logic {
        INTERP_CONST  = 1'b0,  // hold each sample
        INTERP_LINEAR = 1'b1   // mix held and next sample
    } interp_mode_t;

endpackage

`default_nettype wire

// ==== design/aud_ctrl_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aud_settings.svh"

module aud_ctrl_regs (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire logic                       i_wb_cyc,
    input  wire logic                       i_wb_stb,
    input  wire logic                       i_wb_we,
    input  wire logic [`AUD_WB_ADR_W-1:0]   i_wb_adr,
    input  wire logic [31:0]                i_wb_dat,
    output logic      [31:0]                o_wb_dat,
    output logic                            o_wb_ack,
    input  wire aud_pkg::play_state_t       i_state,
    input  wire logic [`AUD_ADDR_W-1:0]     i_addr,
    output logic                            o_start,
    output logic                            o_stop,
    output logic                            o_pause,
    output logic                            o_fast,
    output aud_pkg::interp_mode_t           o_interp,
    output logic      [`AUD_SPEED_W-1:0]    o_speed,
    output logic      [`AUD_ADDR_W-1:0]     o_end_addr
);

    import aud_pkg::*;

    logic                       wb_req;
    logic                       served;    // ack already given for this stb
    logic                       ack_set;
    logic                       wr_en;
    logic [31:0]                ctrl_word;
    logic [31:0]                end_word;
    logic [31:0]                status_word;
    logic [`AUD_SPEED_W-1:0]    wr_speed;

    assign wb_req  = i_wb_cyc && i_wb_stb;
    assign ack_set = wb_req && !o_wb_ack && !served;
    assign wr_en   = o_wb_ack && wb_req && i_wb_we;
    assign wr_speed = i_wb_dat[8 +: `AUD_SPEED_W];

    always_comb begin
        ctrl_word = '0;
        ctrl_word[2] = o_pause;
        ctrl_word[3] = o_fast;
        ctrl_word[4] = o_interp;
        ctrl_word[8 +: `AUD_SPEED_W] = o_speed;
        end_word = '0;
        end_word[`AUD_ADDR_W-1:0] = o_end_addr;
        status_word = '0;
        status_word[1:0] = i_state;
        status_word[8 +: `AUD_ADDR_W] = i_addr;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
            served   <= 1'b0;
        end else begin
            o_wb_ack <= ack_set;
            served   <= wb_req && (served || o_wb_ack);  // clears when stb drops
        end
    end

    // read data is sampled at request, valid during ack
    always_ff @(posedge i_clk) begin
        if (ack_set) begin
            case (i_wb_adr)
                `AUD_REG_CTRL:   o_wb_dat <= ctrl_word;
                `AUD_REG_END:    o_wb_dat <= end_word;
                `AUD_REG_STATUS: o_wb_dat <= status_word;
                default:         o_wb_dat <= '0;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_start    <= 1'b0;
            o_stop     <= 1'b0;
            o_pause    <= 1'b0;
            o_fast     <= 1'b0;
            o_interp   <= INTERP_CONST;
            o_speed    <= '0;
            o_end_addr <= '0;
        end else begin
            o_start <= wr_en && (i_wb_adr == `AUD_REG_CTRL) && i_wb_dat[0];  // one cycle
            o_stop  <= wr_en && (i_wb_adr == `AUD_REG_CTRL) && i_wb_dat[1];
            if (wr_en && (i_wb_adr == `AUD_REG_CTRL)) begin
                o_pause  <= i_wb_dat[2];
                o_fast   <= i_wb_dat[3];
                o_interp <= interp_mode_t'(i_wb_dat[4]);
                o_speed  <= (wr_speed == '0) ? `AUD_SPEED_W'(1) : wr_speed;  // no zero divisor
            end
            if (wr_en && (i_wb_adr == `AUD_REG_END)) begin
                o_end_addr <= i_wb_dat[`AUD_ADDR_W-1:0];
            end
        end
    end

    // a single ack per strobe, and only after the strobe was seen
    ack_after_stb_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |-> $past(i_wb_stb));

endmodule

`default_nettype wire

// ==== design/aud_dsp.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aud_settings.svh"

module aud_dsp (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire logic                       i_start,
    input  wire logic                       i_stop,
    input  wire logic                       i_pause,
    input  wire logic                       i_fast,
    input  wire aud_pkg::interp_mode_t      i_interp,
    input  wire logic [`AUD_SPEED_W-1:0]    i_speed,
    input  wire logic [`AUD_ADDR_W-1:0]     i_end_addr,
    input  wire logic                       i_daclrck,
    input  wire logic [`AUD_SAMPLE_W-1:0]   i_sram_data,
    output logic      [`AUD_ADDR_W-1:0]     o_sram_addr,
    output logic      [`AUD_SAMPLE_W-1:0]   o_dac_data,
    output aud_pkg::play_state_t            o_state
);

    import aud_pkg::*;

    play_state_t                state_r, state_w;
    logic [`AUD_ADDR_W-1:0]     addr_r, addr_w;
    logic [`AUD_SAMPLE_W-1:0]   prev_data_r, prev_data_w;
    logic [`AUD_SAMPLE_W-1:0]   out_data_r, out_data_w;
    logic [`AUD_SPEED_W-1:0]    interp_cnt_r, interp_cnt_w;
    logic                       lrck_d;
    logic                       lrck_fall;
    logic                       backtrack;
    logic [`AUD_ADDR_W-1:0]     speed_ext;
    logic [`AUD_SAMPLE_W-1:0]   recip_prev;
    logic [`AUD_SAMPLE_W-1:0]   recip_cur;
    logic [`AUD_SPEED_W-1:0]    weight_prev;
    logic [19:0]                lin_mix;

    // value / div, upper 16 bits of value times reciprocal
    function automatic logic [15:0] recip_scale(input logic [15:0] value,
                                                input logic [3:0]  div);
        logic [15:0] k;
        logic [31:0] prod;
        case (div)
            4'd3:    k = 16'h5555;
            4'd5:    k = 16'h3333;
            4'd6:    k = 16'h2AAA;
            4'd7:    k = 16'h2492;
            4'd9:    k = 16'h1C71;
            4'd10:   k = 16'h1999;
            4'd11:   k = 16'h1745;
            4'd12:   k = 16'h1555;
            4'd13:   k = 16'h13B1;
            4'd14:   k = 16'h1249;
            4'd15:   k = 16'h1111;
            default: k = 16'h0000;
        endcase
        prod = {16'b0, value} * {16'b0, k};
        case (div)
            4'd0:    recip_scale = 16'hFFFF;
            4'd1:    recip_scale = value;
            4'd2:    recip_scale = value >> 1;
            4'd4:    recip_scale = value >> 2;
            4'd8:    recip_scale = value >> 3;
            default: recip_scale = prod[31:16];
        endcase
    endfunction

    assign lrck_fall   = lrck_d && !i_daclrck;  // start of left half
    assign backtrack   = i_fast && (i_interp == INTERP_LINEAR);
    assign speed_ext   = `AUD_ADDR_W'(i_speed);
    assign recip_prev  = recip_scale(prev_data_r, i_speed);
    assign recip_cur   = recip_scale(i_sram_data, i_speed);
    assign weight_prev = i_speed - interp_cnt_r;
    assign lin_mix     = {4'b0, recip_prev} * {16'b0, weight_prev}
                       + {4'b0, recip_cur} * {16'b0, interp_cnt_r};

    assign o_sram_addr = addr_r;
    assign o_dac_data  = out_data_r;
    assign o_state     = state_r;

    always_comb begin
        state_w      = state_r;
        addr_w       = addr_r;
        prev_data_w  = prev_data_r;
        out_data_w   = out_data_r;
        interp_cnt_w = interp_cnt_r;
        case (state_r)
            S_IDLE: begin
                out_data_w   = '0;
                prev_data_w  = '0;
                interp_cnt_w = '0;
                if (i_start) begin
                    if (backtrack) begin
                        addr_w  = i_end_addr - speed_ext;
                        state_w = S_BACKTRACK;
                    end else begin
                        prev_data_w = i_sram_data;  // word at address 0
                        addr_w      = i_fast ? speed_ext : `AUD_ADDR_W'(1);
                        state_w     = S_PLAY;
                    end
                end
            end
            S_PAUSE: begin
                out_data_w = '0;
                if (i_stop) begin
                    state_w = S_IDLE;
                    addr_w  = '0;
                end else if (!i_pause) begin
                    state_w = S_PLAY;
                end
            end
            S_PLAY: begin
                if (i_pause) begin
                    state_w = S_PAUSE;
                end else if (i_stop) begin
                    state_w = S_IDLE;
                    addr_w  = '0;
                end else if (backtrack) begin
                    state_w = S_BACKTRACK;
                end else if (lrck_fall) begin
                    if (i_fast) begin
                        addr_w      = addr_r + speed_ext;
                        out_data_w  = prev_data_r;
                        prev_data_w = i_sram_data;
                    end else begin
                        if (interp_cnt_r >= i_speed - 1'b1) begin
                            interp_cnt_w = '0;
                            addr_w       = addr_r + 1'b1;
                            prev_data_w  = i_sram_data;
                        end else begin
                            interp_cnt_w = interp_cnt_r + 1'b1;
                        end
                        if (i_interp == INTERP_CONST) begin
                            out_data_w = prev_data_r;
                        end else begin
                            out_data_w = lin_mix[`AUD_SAMPLE_W-1:0];  // truncated
                        end
                    end
                end
            end
            S_BACKTRACK: begin
                if (i_pause) begin
                    state_w = S_PAUSE;
                end else if (i_stop) begin
                    state_w = S_IDLE;
                    addr_w  = '0;
                end else if (!backtrack) begin
                    state_w = S_PLAY;
                end else if (lrck_fall) begin
                    addr_w      = addr_r - speed_ext;
                    out_data_w  = prev_data_r;
                    prev_data_w = i_sram_data;
                end
            end
            default: state_w = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r      <= S_IDLE;
            addr_r       <= '0;
            out_data_r   <= '0;
            interp_cnt_r <= '0;
            lrck_d       <= 1'b0;
        end else begin
            state_r      <= state_w;
            addr_r       <= addr_w;
            out_data_r   <= out_data_w;
            interp_cnt_r <= interp_cnt_w;
            lrck_d       <= i_daclrck;
        end
    end

    always_ff @(posedge i_clk) begin
        prev_data_r <= prev_data_w;
    end

    // address moves only on frame work or a start/stop from the host
    addr_step_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $changed(addr_r) |-> $past(lrck_fall) || $past(i_start) || $past(i_stop));

    idle_hold_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state_r == S_IDLE) && !i_start |=> (state_r == S_IDLE));

endmodule

`default_nettype wire

// ==== design/aud_dac_serializer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aud_settings.svh"

module aud_dac_serializer (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire logic [`AUD_SAMPLE_W-1:0]   i_sample,
    output logic                            o_bclk,
    output logic                            o_lrck,
    output logic                            o_dat
);

    localparam int div_w = ($clog2(`AUD_BCLK_DIV) > 0) ? $clog2(`AUD_BCLK_DIV) : 1;

    logic [div_w-1:0]           div_cnt;
    logic                       div_end;
    logic                       bclk_fall;
    logic [4:0]                 bit_cnt;    // 0..15 left, 16..31 right
    logic [4:0]                 bit_nxt;
    logic [`AUD_SAMPLE_W-1:0]   sample_hold;
    logic [`AUD_SAMPLE_W-1:0]   shreg;

    assign div_end   = (div_cnt == div_w'(`AUD_BCLK_DIV - 1));
    assign bclk_fall = div_end && o_bclk;
    assign bit_nxt   = bit_cnt + 1'b1;
    assign o_lrck    = bit_cnt[4];  // low for left half
    assign o_dat     = shreg[`AUD_SAMPLE_W-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
            o_bclk  <= 1'b0;
        end else if (div_end) begin
            div_cnt <= '0;
            o_bclk  <= !o_bclk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt     <= '0;
            sample_hold <= '0;
            shreg       <= '0;
        end else if (bclk_fall) begin
            bit_cnt <= bit_nxt;
            if (bit_nxt == 5'd0) begin
                sample_hold <= i_sample;  // engine result of the last frame
                shreg       <= i_sample;
            end else if (bit_nxt == 5'd16) begin
                shreg <= sample_hold;  // same word for the right half
            end else begin
                shreg <= shreg << 1;
            end
        end
    end

    lrck_on_bclk_fall_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $changed(o_lrck) |-> $fell(o_bclk));

endmodule

`default_nettype wire

// ==== design/aud_player_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aud_settings.svh"

module aud_player_top (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire logic                       i_wb_cyc,
    input  wire logic                       i_wb_stb,
    input  wire logic                       i_wb_we,
    input  wire logic [`AUD_WB_ADR_W-1:0]   i_wb_adr,
    input  wire logic [31:0]                i_wb_dat,
    output logic      [31:0]                o_wb_dat,
    output logic                            o_wb_ack,
    output logic      [`AUD_ADDR_W-1:0]     o_sram_addr,
    input  wire logic [`AUD_SAMPLE_W-1:0]   i_sram_data,
    output logic                            o_dac_bclk,
    output logic                            o_dac_lrck,
    output logic                            o_dac_dat
);

    import aud_pkg::*;

    logic                       start;
    logic                       stop;
    logic                       pause;
    logic                       fast;
    interp_mode_t               interp;
    logic [`AUD_SPEED_W-1:0]    speed;
    logic [`AUD_ADDR_W-1:0]     end_addr;
    play_state_t                state;
    logic [`AUD_SAMPLE_W-1:0]   sample;

    aud_ctrl_regs u_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .i_state    (state),
        .i_addr     (o_sram_addr),  // current play position for STATUS
        .o_start    (start),
        .o_stop     (stop),
        .o_pause    (pause),
        .o_fast     (fast),
        .o_interp   (interp),
        .o_speed    (speed),
        .o_end_addr (end_addr)
    );

    aud_dsp u_dsp (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (start),
        .i_stop      (stop),
        .i_pause     (pause),
        .i_fast      (fast),
        .i_interp    (interp),
        .i_speed     (speed),
        .i_end_addr  (end_addr),
        .i_daclrck   (o_dac_lrck),
        .i_sram_data (i_sram_data),
        .o_sram_addr (o_sram_addr),
        .o_dac_data  (sample),
        .o_state     (state)
    );

    aud_dac_serializer u_dac (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_sample (sample),
        .o_bclk   (o_dac_bclk),
        .o_lrck   (o_dac_lrck),
        .o_dat    (o_dac_dat)
    );

endmodule

`default_nettype wire

// ==== bench/aud_tb_tasks.svh ====
`ifndef AUD_TB_TASKS_SVH
`define AUD_TB_TASKS_SVH

localparam int MODE_FAST   = 0;
localparam int MODE_HOLD   = 1;
localparam int MODE_LINEAR = 2;
localparam int MODE_BACK   = 3;

task automatic report_failure(input string what);
    $display("%s at time %0t", what, $time);
    $display("TESTBENCH FAILED");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        $display("mismatch at time %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end
endtask

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

task automatic fill_sram();
    logic [15:0] lfsr;
    logic [15:0] word;
    int a;
    int b;
    lfsr = 16'd13;
    for (a = 0; a < MEM_WORDS; a++) begin
        word = '0;
        for (b = 0; b < 16; b++) begin
            lfsr = lfsr_next(lfsr);
            word = {word[14:0], lfsr[0]};  // one step per bit
        end
        sram_mem[a] = word | 16'h0001;  // never zero
    end
endtask

function automatic logic [31:0] ctrl_bits(input logic start, input logic stop,
                                          input logic pause, input logic fast,
                                          input logic linear, input int speed);
    return {20'b0, 4'(speed), 3'b0, linear, fast, pause, stop, start};
endfunction

function automatic int mem_at(input int addr);
    return sram_mem[addr & 10'h3FF];
endfunction

// value / div as the reciprocal table gives it
function automatic int div_ref(input int value, input int div);
    if ((div & (div - 1)) == 0) begin
        return value / div;
    end
    return (value * (65535 / div)) >> 16;
endfunction

task automatic build_expected(input int mode, input int speed, input int end_addr,
                              input int count);
    int i;
    int mix;
    exp_q.delete();
    for (i = 0; i < count; i++) begin
        case (mode)
            MODE_FAST: exp_q.push_back(16'(mem_at(i * speed)));
            MODE_HOLD: exp_q.push_back(16'(mem_at(i / speed)));
            MODE_LINEAR: begin
                mix = div_ref(mem_at(i / speed), speed) * (speed - i % speed)
                    + div_ref(mem_at(i / speed + 1), speed) * (i % speed);
                exp_q.push_back(16'(mix));  // truncated
            end
            default: exp_q.push_back(16'(mem_at(end_addr - (i + 1) * speed)));
        endcase
    end
endtask

task automatic wait_ack();
    int cycles;
    cycles = 0;
    do begin
        @(posedge clk);
        cycles++;
    end while (!wb_ack && cycles < 8);
    if (!wb_ack) begin
        report_failure("no wishbone ack within 8 cycles");
    end
endtask

task automatic wb_write(input logic [`AUD_WB_ADR_W-1:0] adr, input logic [31:0] dat);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    wait_ack();
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
endtask

task automatic wb_read(input logic [`AUD_WB_ADR_W-1:0] adr, output logic [31:0] dat);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    wait_ack();
    dat = wb_dat_r;  // held during ack
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
endtask

// left channel word of the next frame
task automatic capture_frame(output logic [15:0] word);
    logic prev;
    logic seen;
    int cycles;
    int b;
    word = '0;
    cycles = 0;
    @(negedge clk);
    prev = dac_lrck;
    do begin
        @(negedge clk);
        cycles++;
        seen = prev && !dac_lrck;
        prev = dac_lrck;
    end while (!seen && cycles < 300);
    if (!seen) begin
        report_failure("no falling lrck within 300 cycles");
    end
    for (b = 0; b < 16; b++) begin
        cycles = 0;
        prev = dac_bclk;
        do begin
            @(negedge clk);
            cycles++;
            seen = !prev && dac_bclk;
            prev = dac_bclk;
        end while (!seen && cycles < 8);
        if (!seen) begin
            report_failure("no rising bclk within 8 cycles");
        end
        word = {word[14:0], dac_dat};  // msb first
    end
endtask

task automatic capture_run(input int count);
    logic [15:0] word;
    int skipped;
    got_q.delete();
    skipped = 0;
    capture_frame(word);
    while (word == 16'h0 && skipped < 8) begin
        skipped++;
        capture_frame(word);
    end
    if (word == 16'h0) begin
        report_failure("output stayed silent after start");
    end
    got_q.push_back(word);
    while (got_q.size() < count) begin
        capture_frame(word);
        got_q.push_back(word);
    end
endtask

task automatic compare_run(input string what);
    int i;
    for (i = 0; i < got_q.size(); i++) begin
        check_value($sformatf("o_dac_dat %s frame %0d", what, i), got_q[i], exp_q[i]);
    end
endtask

task automatic expect_silence(input string what);
    logic [15:0] word;
    int i;
    for (i = 0; i < 3; i++) begin
        capture_frame(word);
        check_value($sformatf("o_dac_dat %s frame %0d", what, i), word, 0);
    end
endtask

task automatic stop_playback();
    wb_write(`AUD_REG_CTRL, ctrl_bits(0, 1, 0, 0, 0, 0));
endtask

task automatic check_reset_regs();
    logic [31:0] data;
    wb_read(`AUD_REG_CTRL, data);
    check_value("CTRL after reset", data, 0);
    wb_read(`AUD_REG_END, data);
    check_value("END after reset", data, 0);
    wb_read(`AUD_REG_STATUS, data);
    check_value("STATUS after reset", data, {30'b0, S_IDLE});
    wb_write(`AUD_REG_END, 32'hFFF1_2345);
    wb_read(`AUD_REG_END, data);
    check_value("END readback", data, 32'h0001_2345);  // 20 bits kept
    wb_write(`AUD_REG_CTRL, ctrl_bits(0, 0, 0, 1, 1, 5));
    wb_read(`AUD_REG_CTRL, data);
    check_value("CTRL readback", data, 32'h0000_0518);
    wb_write(`AUD_REG_CTRL, ctrl_bits(0, 0, 0, 0, 1, 0));
    wb_read(`AUD_REG_CTRL, data);
    check_value("CTRL speed 0 readback", data, 32'h0000_0110);
endtask

task automatic fast_forward_seq();
    logic [31:0] status;
    logic [15:0] word;
    int first_addr;
    wb_write(`AUD_REG_CTRL, ctrl_bits(1, 0, 0, 1, 0, 3));
    build_expected(MODE_FAST, 3, 0, 8);
    capture_run(8);
    compare_run("fast");
    wb_read(`AUD_REG_STATUS, status);
    check_value("STATUS state", status[1:0], S_PLAY);
    first_addr = status[27:8];
    check_value("STATUS addr mod 3", first_addr % 3, 0);
    capture_frame(word);  // exactly one frame step
    check_value("o_dac_dat fast frame 8", word, mem_at(8 * 3));
    wb_read(`AUD_REG_STATUS, status);
    check_value("STATUS addr step", status[27:8] - first_addr, 3);
    stop_playback();
endtask

task automatic slow_hold_seq();
    wb_write(`AUD_REG_CTRL, ctrl_bits(1, 0, 0, 0, 0, 4));
    build_expected(MODE_HOLD, 4, 0, 12);
    capture_run(12);
    compare_run("slow hold");
    stop_playback();
endtask

task automatic linear_mix_seq(input int speed);
    wb_write(`AUD_REG_CTRL, ctrl_bits(1, 0, 0, 0, 1, speed));
    build_expected(MODE_LINEAR, speed, 0, 3 * speed);
    capture_run(3 * speed);
    compare_run($sformatf("linear speed %0d", speed));
    stop_playback();
endtask

task automatic backtrack_seq();
    logic [31:0] status;
    wb_write(`AUD_REG_END, 32'h0000_0200);
    wb_write(`AUD_REG_CTRL, ctrl_bits(1, 0, 0, 1, 1, 2));
    build_expected(MODE_BACK, 2, 'h200, 8);
    capture_run(8);
    compare_run("backtrack");
    wb_read(`AUD_REG_STATUS, status);
    check_value("STATUS state", status[1:0], S_BACKTRACK);
    stop_playback();
endtask

task automatic pause_resume_stop();
    logic [31:0] status;
    int held;
    wb_write(`AUD_REG_CTRL, ctrl_bits(1, 0, 0, 1, 0, 1));
    build_expected(MODE_FAST, 1, 0, 4);
    capture_run(4);
    compare_run("before pause");
    wb_write(`AUD_REG_CTRL, ctrl_bits(0, 0, 1, 1, 0, 1));
    wb_read(`AUD_REG_STATUS, status);
    check_value("STATUS state", status[1:0], S_PAUSE);
    held = status[27:8];
    expect_silence("paused");
    wb_read(`AUD_REG_STATUS, status);
    check_value("STATUS paused addr", status[27:8], held);
    wb_write(`AUD_REG_CTRL, ctrl_bits(0, 0, 0, 1, 0, 1));
    build_expected(MODE_FAST, 1, 0, held + 2);
    repeat (held - 1) void'(exp_q.pop_front());  // resumes with the held sample
    capture_run(3);
    compare_run("resumed");
    stop_playback();
    wb_read(`AUD_REG_STATUS, status);
    check_value("STATUS after stop", status, {30'b0, S_IDLE});
    expect_silence("stopped");
endtask

`endif

// ==== bench/aud_player_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aud_settings.svh"

module aud_player_tb;

    import aud_pkg::*;

    localparam int MEM_WORDS = 1024;

    logic                       clk;
    logic                       rst_n;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [`AUD_WB_ADR_W-1:0]   wb_adr;
    logic [31:0]                wb_dat_w;
    logic [31:0]                wb_dat_r;
    logic                       wb_ack;
    logic [`AUD_ADDR_W-1:0]     sram_addr;
    logic [`AUD_SAMPLE_W-1:0]   sram_data;
    logic                       dac_bclk;
    logic                       dac_lrck;
    logic                       dac_dat;
    logic [`AUD_SAMPLE_W-1:0]   sram_mem [MEM_WORDS];
    logic [15:0]                exp_q [$];  // model samples
    logic [15:0]                got_q [$];  // captured samples

    assign sram_data = sram_mem[sram_addr[9:0]];  // combinational read

    always #10 clk = !clk;

    aud_player_top i_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_we     (wb_we),
        .i_wb_adr    (wb_adr),
        .i_wb_dat    (wb_dat_w),
        .o_wb_dat    (wb_dat_r),
        .o_wb_ack    (wb_ack),
        .o_sram_addr (sram_addr),
        .i_sram_data (sram_data),
        .o_dac_bclk  (dac_bclk),
        .o_dac_lrck  (dac_lrck),
        .o_dac_dat   (dac_dat)
    );

    `include "aud_tb_tasks.svh"

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        fill_sram();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_reset_regs();
        fast_forward_seq();
        slow_hold_seq();
        linear_mix_seq(2);
        linear_mix_seq(3);
        backtrack_seq();
        pause_resume_stop();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== aud_player_top.f ====
+incdir+design
+incdir+bench
design/aud_pkg.sv
design/aud_ctrl_regs.sv
design/aud_dsp.sv
design/aud_dac_serializer.sv
design/aud_player_top.sv
bench/aud_player_tb.sv
